//--- filelist.f
source/zx_pkg.sv
source/zbus_if.sv
source/paging_cfg_if.sv
source/zports.sv
source/window_pager.sv
source/zdos.sv
source/zmem_map.sv
source/pentevo_mem_top.sv
dv/pentevo_mem_chk.sv
dv/tb_pentevo_mem.sv

//--- Bender.yml
package:
  name: pentevo_mem

sources:
  # design, in compile order
  - source/zx_pkg.sv
  - source/zbus_if.sv
  - source/paging_cfg_if.sv
  - source/zports.sv
  - source/window_pager.sv
  - source/zdos.sv
  - source/zmem_map.sv
  - source/pentevo_mem_top.sv

  # verification
  - target: test
    files:
      - dv/pentevo_mem_chk.sv
      - dv/tb_pentevo_mem.sv

//--- dv/tb_pentevo_mem.sv
`timescale 1ns/1ps

module tb_pentevo_mem;

	// 6 tests, 200 cycles each, 4 ns clock
	localparam int wd_ns = 6 * 200 * 4;

	logic        dclk = 1'b0;
	logic        rst;
	logic [15:0] a;
	logic [7:0]  d_in;
	logic        iorq_n;
	logic        mreq_n;
	logic        rd_n;
	logic        wr_n;
	logic        m1_n;
	logic [7:0]  d_out;
	logic        d_oe;
	logic [20:0] mem_addr;
	logic        rom_cs;
	logic        ram_cs;
	logic        beep;

	// model state
	logic       m_pen;
	logic [7:0] m_p7ffd;
	logic       m_dos;
	logic       m_beep;
	logic [7:0] m_atm [4];

	logic        chk_req;
	logic [7:0]  exp_map;
	logic [20:0] exp_addr;
	logic        exp_rom;
	logic        exp_ram;
	logic        exp_oe;
	logic [7:0]  rnd_d;
	logic [15:0] rnd_a;
	integer      seed;
	int          err_cnt;
	int          err_mark;
	int          tests_run;
	int          pass_cnt;
	int          fail_cnt;

	pentevo_mem_top UUT (
		.dclk    (dclk),
		.rst     (rst),
		.a       (a),
		.d_in    (d_in),
		.iorq_n  (iorq_n),
		.mreq_n  (mreq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.m1_n    (m1_n),
		.d_out   (d_out),
		.d_oe    (d_oe),
		.mem_addr(mem_addr),
		.rom_cs  (rom_cs),
		.ram_cs  (ram_cs),
		.beep    (beep)
	);

	always #2 dclk = ~dclk;

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	// expected {rom, page} of one window
	function automatic logic [7:0] ref_map(input logic [1:0] win);
		if (m_pen)
			return m_atm[win];
		case (win)
			2'd0:    return {1'b1, 5'b0, m_dos, m_p7ffd[4]};
			2'd1:    return 8'h05;
			2'd2:    return 8'h02;
			default: return {5'b0, m_p7ffd[2:0]};
		endcase
	endfunction

	// compare failures plus failures of the bound assertions
	function automatic int error_total();
		return err_cnt + UUT.u_chk.asrt_fails;
	endfunction

	// mid-cycle compare while a bus cycle is in its second clock
	always @(negedge dclk)
	begin
		if (chk_req)
		begin
			exp_map  = ref_map(a[15:14]);
			exp_addr = {exp_map[6:0], a[13:0]};
			exp_rom  = !mreq_n && exp_map[7];
			exp_ram  = !mreq_n && !exp_map[7];
			exp_oe   = !iorq_n && !rd_n && (a[7:0] == 8'hBE);
			if (mem_addr !== exp_addr)
			begin
				$display("Mismatch mem_addr exp %h got %h", exp_addr, mem_addr);
				err_cnt++;
			end
			if (rom_cs !== exp_rom || ram_cs !== exp_ram)
			begin
				$display("Mismatch rom_cs/ram_cs exp %h got %h", {exp_rom, exp_ram},
					{rom_cs, ram_cs});
				err_cnt++;
			end
			if (d_oe !== exp_oe)
			begin
				$display("Mismatch d_oe exp %h got %h", exp_oe, d_oe);
				err_cnt++;
			end
			if (exp_oe && d_out !== ref_map(a[9:8]))
			begin
				$display("Mismatch d_out exp %h got %h", ref_map(a[9:8]), d_out);
				err_cnt++;
			end
			if (beep !== m_beep)
			begin
				$display("Mismatch beep exp %h got %h", m_beep, beep);
				err_cnt++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// bus cycles
	//////////////////////////////////////////////////////////////////////

	task automatic drive_cycle(input logic [15:0] addr, input logic [7:0] data,
		input logic io, input logic rd, input logic m1);
		logic [7:0] w0;
		@(posedge dclk);
		#1;
		a      = addr;
		d_in   = data;
		iorq_n = !io;
		mreq_n = io;
		rd_n   = !rd;
		wr_n   = rd;
		m1_n   = !m1;
		@(posedge dclk);
		#1;
		// strobe was taken on the edge just passed
		w0 = ref_map(2'd0);
		if (io && !rd)
		begin
			if (addr == 16'h7FFD)
				m_p7ffd = data;
			if (addr[7:0] == 8'h77)
				m_pen = data[0];
			if (addr[7:0] == 8'hFE)
				m_beep = data[4];
			if (addr[7:0] == 8'hF7)
				m_atm[addr[15:14]] = data;
		end
		if (m1)
		begin
			if (addr[15:8] == 8'h3D && w0[7] && w0[0])
				m_dos = 1'b1;
			else if (addr[15:14] != 2'b00)
				m_dos = 1'b0;
		end
		chk_req = 1'b1;
		@(posedge dclk);
		#1;
		chk_req = 1'b0;
		iorq_n  = 1'b1;
		mreq_n  = 1'b1;
		rd_n    = 1'b1;
		wr_n    = 1'b1;
		m1_n    = 1'b1;
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		drive_cycle(addr, data, 1'b1, 1'b0, 1'b0);
	endtask

	task automatic io_read(input logic [15:0] addr);
		drive_cycle(addr, 8'h00, 1'b1, 1'b1, 1'b0);
	endtask

	task automatic mem_read(input logic [15:0] addr);
		drive_cycle(addr, 8'h00, 1'b0, 1'b1, 1'b0);
	endtask

	task automatic mem_fetch(input logic [15:0] addr);
		drive_cycle(addr, 8'h00, 1'b0, 1'b1, 1'b1);
	endtask

	task automatic finish_test(input string name);
		int errs;
		errs = error_total() - err_mark;
		tests_run++;
		if (errs == 0)
		begin
			pass_cnt++;
			$display("test %0d %s: ok", tests_run, name);
		end
		else
		begin
			fail_cnt++;
			$display("test %0d %s: %0d errors", tests_run, name, errs);
		end
		err_mark = error_total();
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		seed      = 32'h477c_c608;
		rst       = 1'b1;
		a         = '0;
		d_in      = '0;
		iorq_n    = 1'b1;
		mreq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		m1_n      = 1'b1;
		chk_req   = 1'b0;
		m_pen     = 1'b0;
		m_p7ffd   = '0;
		m_dos     = 1'b0;
		m_beep    = 1'b0;
		m_atm[0]  = 8'h80;
		m_atm[1]  = 8'h05;
		m_atm[2]  = 8'h02;
		m_atm[3]  = 8'h00;
		err_cnt   = 0;
		err_mark  = 0;
		tests_run = 0;
		pass_cnt  = 0;
		fail_cnt  = 0;
		repeat (3) @(posedge dclk);
		#1;
		rst = 1'b0;

		for (int w = 0; w < 4; w++)
			mem_read({w[1:0], 14'h0123});
		finish_test("reset mapping");

		for (int i = 0; i < 8; i++)
		begin
			rnd_d = $random(seed);
			rnd_a = $random(seed);
			io_write(16'h7FFD, rnd_d);
			mem_read({2'b11, rnd_a[13:0]});
			mem_read({2'b00, rnd_a[13:0]});
		end
		finish_test("7ffd paging");

		// basic48 rom selected, then trap and leave
		io_write(16'h7FFD, 8'h10);
		mem_fetch(16'h3D2F);
		mem_read(16'h0100);
		mem_fetch(16'h8000);
		mem_read(16'h0100);
		finish_test("dos rom flag");

		io_write(16'h0077, 8'h01);
		for (int w = 0; w < 4; w++)
		begin
			rnd_d = $random(seed);
			rnd_a = $random(seed);
			io_write({w[1:0], rnd_a[5:0], 8'hF7}, rnd_d);
		end
		for (int w = 0; w < 4; w++)
		begin
			rnd_a = $random(seed);
			mem_read({w[1:0], rnd_a[13:0]});
		end
		finish_test("atm paging");

		for (int pass = 0; pass < 2; pass++)
		begin
			for (int w = 0; w < 4; w++)
			begin
				rnd_a = $random(seed);
				io_read({rnd_a[5:0], w[1:0], 8'hBE});
			end
			// back to pentagon maps for the second round
			io_write(16'h0077, 8'h00);
		end
		io_read(16'h00FE);
		io_read(16'h7FFD);
		io_read(16'h0077);
		finish_test("window readback");

		for (int i = 0; i < 8; i++)
		begin
			rnd_d = $random(seed);
			rnd_a = $random(seed);
			io_write({rnd_a[7:0], 8'hFE}, rnd_d);
		end
		finish_test("beeper");

		@(posedge dclk);
		$display("summary: %0d tests ok, %0d with errors", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && error_total() == err_mark)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog
	initial
	begin
		#(wd_ns);
		$display("watchdog expired before all tests finished");
		$display("Test failed");
		$finish;
	end

endmodule

//--- dv/pentevo_mem_chk.sv
`timescale 1ns/1ps

module pentevo_mem_chk (
	input logic dclk,
	input logic rst,
	input logic iorq_n,
	input logic mreq_n,
	input logic rd_n,
	input logic m1_n,
	input logic d_oe,
	input logic rom_cs,
	input logic ram_cs,
	input logic dos
);

	// running count of assertion failures
	int asrt_fails = 0;

	//////////////////////////////////////////////////////////////////////
	// bus side rules
	//////////////////////////////////////////////////////////////////////

	// readback only drives during an i/o read
	a_doe_io_read: assert property (@(posedge dclk) disable iff (rst)
		d_oe |-> (!iorq_n && !rd_n))
	else
	begin
		$error("d_oe high outside an i/o read");
		asrt_fails++;
	end

	// one select at a time, only in a memory cycle
	a_cs_mreq: assert property (@(posedge dclk) disable iff (rst)
		(rom_cs || ram_cs) |-> (!mreq_n && !(rom_cs && ram_cs)))
	else
	begin
		$error("bad rom_cs/ram_cs combination");
		asrt_fails++;
	end

	// dos flag moves only right after an opcode fetch
	a_dos_m1: assert property (@(posedge dclk) disable iff (rst)
		(dos != $past(dos)) |-> $past(!m1_n && !mreq_n && !rd_n))
	else
	begin
		$error("dos changed without an m1 fetch");
		asrt_fails++;
	end

endmodule

bind pentevo_mem_top pentevo_mem_chk u_chk (
	.dclk  (dclk),
	.rst   (rst),
	.iorq_n(iorq_n),
	.mreq_n(mreq_n),
	.rd_n  (rd_n),
	.m1_n  (m1_n),
	.d_oe  (d_oe),
	.rom_cs(rom_cs),
	.ram_cs(ram_cs),
	.dos   (dos)
);

//--- source/pentevo_mem_top.sv
`timescale 1ns/1ps

module pentevo_mem_top (
	input  logic                       dclk,
	input  logic                       rst,

	// z80 bus
	input  logic [15:0]                a,
	input  logic [7:0]                 d_in,
	input  logic                       iorq_n,
	input  logic                       mreq_n,
	input  logic                       rd_n,
	input  logic                       wr_n,
	input  logic                       m1_n,

	// port readback
	output logic [7:0]                 d_out,
	output logic                       d_oe,

	// memory side
	output logic [zx_pkg::maddr_w-1:0] mem_addr,
	output logic                       rom_cs,
	output logic                       ram_cs,

	output logic                       beep
);
	import zx_pkg::*;

	zbus_if       bus ();
	paging_cfg_if cfg ();

	win_map_t win_maps [win_cnt];
	logic     dos;

	assign bus.addr   = a;
	assign bus.wdata  = d_in;
	assign bus.iorq_n = iorq_n;
	assign bus.mreq_n = mreq_n;
	assign bus.rd_n   = rd_n;
	assign bus.wr_n   = wr_n;
	assign bus.m1_n   = m1_n;

	zports u_zports (
		.dclk (dclk),
		.rst  (rst),
		.bus  (bus.snoop),
		.cfg  (cfg.ports),
		.maps (win_maps),
		.d_out(d_out),
		.d_oe (d_oe),
		.beep (beep)
	);

	//////////////////////////////////////////////////////////////////////
	// window pagers
	//////////////////////////////////////////////////////////////////////

	// only window 0 carries the dos rom
	for (genvar i = 0; i < win_cnt; i++)
	begin : g_pager
		window_pager #(.win(i)) u_pager (
			.dclk(dclk),
			.rst (rst),
			.cfg (cfg.pager),
			.dos ((i == 0) ? dos : 1'b0),
			.map (win_maps[i])
		);
	end

	zdos u_zdos (
		.dclk(dclk),
		.rst (rst),
		.bus (bus.snoop),
		.win0(win_maps[0]),
		.dos (dos)
	);

	zmem_map u_zmem_map (
		.bus     (bus.snoop),
		.maps    (win_maps),
		.mem_addr(mem_addr),
		.rom_cs  (rom_cs),
		.ram_cs  (ram_cs)
	);

endmodule

//--- source/zmem_map.sv
`timescale 1ns/1ps

module zmem_map (
	zbus_if.snoop                        bus,
	input  zx_pkg::win_map_t             maps [zx_pkg::win_cnt],
	output logic [zx_pkg::maddr_w-1:0]   mem_addr,
	output logic                         rom_cs,
	output logic                         ram_cs
);
	import zx_pkg::*;

	win_map_t cur;
	logic     mreq;

	//////////////////////////////////////////////////////////////////////
	// window select
	//////////////////////////////////////////////////////////////////////

	// top two address bits pick one of the four windows
	assign cur = maps[bus.addr[15:14]];

	//////////////////////////////////////////////////////////////////////
	// memory address and chip selects
	//////////////////////////////////////////////////////////////////////

	// page on top, offset passes straight through
	assign mem_addr = {cur.page, bus.addr[offs_w-1:0]};

	assign mreq = !bus.mreq_n;

	// exactly one select during a memory cycle
	assign rom_cs = mreq && cur.rom;
	assign ram_cs = mreq && !cur.rom;

endmodule

//--- source/zdos.sv
`timescale 1ns/1ps

module zdos (
	input  logic             dclk,
	input  logic             rst,
	zbus_if.snoop            bus,
	input  zx_pkg::win_map_t win0,
	output logic             dos
);
	import zx_pkg::*;

	logic m1_req;
	logic m1_prev;
	logic m1_edge;

	assign m1_req  = !bus.m1_n && !bus.mreq_n && !bus.rd_n;
	assign m1_edge = m1_req && !m1_prev;

	always_ff @(posedge dclk)
	begin
		if (rst)
		begin
			m1_prev <= 1'b0;
			dos     <= 1'b0;
		end
		else
		begin
			m1_prev <= m1_req;

			// enter trdos only from the basic48 rom
			if (m1_edge && bus.addr[15:8] == dos_trap_hi && win0.rom && win0.page[0])
				dos <= 1'b1;
			// any opcode fetched above 4000 leaves it
			else if (m1_edge && bus.addr[15:14] != 2'b00)
				dos <= 1'b0;
		end
	end

endmodule

//--- source/window_pager.sv
`timescale 1ns/1ps

module window_pager #(
	parameter int win = 0
) (
	input  logic             dclk,
	input  logic             rst,
	paging_cfg_if.pager      cfg,
	input  logic             dos,
	output zx_pkg::win_map_t map
);
	import zx_pkg::*;

	// what pentagon mode puts here straight after reset
	localparam logic [page_w-1:0] dflt_page =
		(win == 1) ? pent_page_w1 :
		(win == 2) ? pent_page_w2 : page_w'(0);

	localparam win_map_t pent_dflt = '{rom: (win == 0), page: dflt_page};

	win_map_t atm_reg;
	win_map_t pent_map;

	//////////////////////////////////////////////////////////////////////
	// atm page register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge dclk)
	begin
		if (rst)
			atm_reg <= pent_dflt;
		else if (cfg.win_we[win])
			atm_reg <= cfg.win_wdata;
	end

	//////////////////////////////////////////////////////////////////////
	// pentagon 128 mapping
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		pent_map = pent_dflt;
		case (win)
			// basic48, basic128, trdos and the shadow rom
			0:
			begin
				pent_map.rom  = 1'b1;
				pent_map.page = {{(page_w - 2){1'b0}}, dos, cfg.p7ffd[4]};
			end
			1:
				pent_map.page = pent_page_w1;
			2:
				pent_map.page = pent_page_w2;
			// only window 3 follows the 7FFD ram bits
			default:
			begin
				pent_map.rom  = 1'b0;
				pent_map.page = {{(page_w - 3){1'b0}}, cfg.p7ffd[2:0]};
			end
		endcase
	end

	assign map = cfg.pen ? atm_reg : pent_map;

endmodule

//--- source/zports.sv
`timescale 1ns/1ps

module zports (
	input  logic             dclk,
	input  logic             rst,
	zbus_if.snoop            bus,
	paging_cfg_if.ports      cfg,
	input  zx_pkg::win_map_t maps [zx_pkg::win_cnt],
	output logic [7:0]       d_out,
	output logic             d_oe,
	output logic             beep
);
	import zx_pkg::*;

	logic wr_req;
	logic wr_prev;
	logic wr_edge;
	logic rd_req;

	logic hit_7ffd;
	logic hit_77;
	logic hit_fe;
	logic hit_f7;
	logic hit_be;

	//////////////////////////////////////////////////////////////////////
	// strobes and address decode
	//////////////////////////////////////////////////////////////////////

	assign wr_req = !bus.iorq_n && !bus.wr_n;
	assign rd_req = !bus.iorq_n && !bus.rd_n;

	// act once per write cycle, however long the strobe is held
	assign wr_edge = wr_req && !wr_prev;

	assign hit_7ffd = (bus.addr == port_7ffd);
	assign hit_77   = (bus.addr[7:0] == port_lo_77);
	assign hit_fe   = (bus.addr[7:0] == port_lo_fe);
	assign hit_f7   = (bus.addr[7:0] == port_lo_f7);
	assign hit_be   = (bus.addr[7:0] == port_lo_be);

	//////////////////////////////////////////////////////////////////////
	// port registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge dclk)
	begin
		if (rst)
		begin
			wr_prev   <= 1'b0;
			cfg.pen   <= 1'b0;
			cfg.p7ffd <= '0;
			beep      <= 1'b0;
		end
		else
		begin
			wr_prev <= wr_req;

			if (wr_edge)
			begin
				if (hit_7ffd)
					cfg.p7ffd <= bus.wdata;

				// xx77 bit 0 turns the atm pagers on
				if (hit_77)
					cfg.pen <= bus.wdata[0];

				if (hit_fe)
					beep <= bus.wdata[4];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// window page writes via xxF7
	//////////////////////////////////////////////////////////////////////

	// a15..a14 pick the window, pager latches on the same edge
	always_comb
	begin
		cfg.win_we = '0;
		if (wr_edge && hit_f7)
			cfg.win_we[bus.addr[15:14]] = 1'b1;
	end

	assign cfg.win_wdata = bus.wdata;

	//////////////////////////////////////////////////////////////////////
	// readback via xxBE
	//////////////////////////////////////////////////////////////////////

	// a9..a8 select the window, rom flag lands in bit 7
	assign d_out = maps[bus.addr[9:8]];
	assign d_oe  = rd_req && hit_be;

endmodule

//--- source/paging_cfg_if.sv
`timescale 1ns/1ps

interface paging_cfg_if;
	import zx_pkg::*;

	// atm pager enable, 0 means pentagon mapping
	logic pen;

	// last value written to 7FFD
	logic [7:0] p7ffd;

	// one-hot load strobe for the window page registers
	logic [win_cnt-1:0] win_we;
	logic [7:0]         win_wdata;

	modport ports (
		output pen, p7ffd,
		output win_we, win_wdata
	);

	modport pager (
		input pen, p7ffd,
		input win_we, win_wdata
	);

endinterface

//--- source/zbus_if.sv
`timescale 1ns/1ps

interface zbus_if;

	// address and data as seen on the z80 side
	logic [15:0] addr;
	logic [7:0]  wdata;

	// strobes, all active low
	logic iorq_n;
	logic mreq_n;
	logic rd_n;
	logic wr_n;
	logic m1_n;

	// the side that drives the bus
	modport host (
		output addr, wdata,
		output iorq_n, mreq_n, rd_n, wr_n, m1_n
	);

	// decoders that only watch it
	modport snoop (
		input addr, wdata,
		input iorq_n, mreq_n, rd_n, wr_n, m1_n
	);

endinterface

//--- source/zx_pkg.sv
package zx_pkg;

	//////////////////////////////////////////////////////////////////////
	// memory geometry
	//////////////////////////////////////////////////////////////////////

	// four 16K windows cover the z80 address space
	localparam int win_cnt = 4;

	// page number and offset inside a window
	localparam int page_w  = 7;
	localparam int offs_w  = 14;

	// page in the upper bits, offset in the lower ones
	localparam int maddr_w = page_w + offs_w;

	// one window's mapping, rom flag on top so the byte reads back as is
	typedef struct packed {
		logic              rom;
		logic [page_w-1:0] page;
	} win_map_t;

	//////////////////////////////////////////////////////////////////////
	// i/o port addresses
	//////////////////////////////////////////////////////////////////////

	// pentagon 128 paging, full decode
	localparam logic [15:0] port_7ffd = 16'h7FFD;

	// low byte decodes
	localparam logic [7:0] port_lo_fe = 8'hFE;
	localparam logic [7:0] port_lo_77 = 8'h77;
	localparam logic [7:0] port_lo_f7 = 8'hF7;
	localparam logic [7:0] port_lo_be = 8'hBE;

	//////////////////////////////////////////////////////////////////////
	// dos rom and fixed pentagon pages
	//////////////////////////////////////////////////////////////////////

	// trdos entry point lives at 3Dxx
	localparam logic [7:0] dos_trap_hi = 8'h3D;

	// ram pages hard-wired to windows 1 and 2
	localparam logic [page_w-1:0] pent_page_w1 = 7'd5;
	localparam logic [page_w-1:0] pent_page_w2 = 7'd2;

endpackage
